//--- list.f
+incdir+verilog
verilog/uopPkg.sv
verilog/laneBusPkg.sv
verilog/exStage2Latch.sv
verilog/exStage3Lane.sv
verilog/exWriteback.sv
verilog/exPipeTop.sv
verif/tbClockGen.sv
verif/exPipeChecker.sv
verif/exPipeTb.sv

//--- run.sh
#!/bin/sh
# Build and run the EX3 pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module exPipeTb -Mdir obj_dir -o exPipeSim
./obj_dir/exPipeSim | tee sim.log
grep -q "ALL CHECKS PASSED" sim.log
echo "Simulation run succeeded"

//--- verif/exPipeChecker.sv
// ##############################
// Testbench checker
// Model of latch, lanes, GPR file
// and faults, compared every rising edge
// ##############################

`timescale 1ns/1ps

`include "core_defines.svh"

module exPipeChecker (
	input logic clock,
	input logic reset,
	input laneBusPkg::ex2Bus_t [`CORE_LANES-1:0] laneIn,
	input laneBusPkg::memRsp_t [`CORE_LANES-1:0] memRsp,
	input logic flush,
	input logic stall,
	input laneBusPkg::retire_t [`CORE_LANES-1:0] retire,
	input logic [`CORE_LANES-1:0] laneFault,
	input uopPkg::gprId_t dbgGprId,
	input logic [63:0] dbgGprVal,
	output int errorCount
);

	localparam uopPkg::gprId_t gprZzr = uopPkg::gprId_t'(`CORE_ZZR);
	localparam uopPkg::crId_t crZzr = uopPkg::crId_t'(`CORE_ZZR);

	laneBusPkg::ex2Bus_t mEx3 [`CORE_LANES]; // Ops the model holds in EX3
	laneBusPkg::retire_t mRet [`CORE_LANES]; // Expected retire after this edge
	logic [63:0] mGpr [`CORE_GPRS];
	logic [`CORE_LANES-1:0] mFault;
	laneBusPkg::wbReq_t req [`CORE_LANES];
	logic expStall;

	initial errorCount = 0;

	function automatic logic isMemOp(input uopPkg::uCmd_t cmd);
		return cmd == uopPkg::UCMD_MOV_MR || cmd == uopPkg::UCMD_MOV_RM;
	endfunction

	// Destination pair one lane should present
	function automatic laneBusPkg::wbReq_t expectReq(input laneBusPkg::ex2Bus_t op,
			input laneBusPkg::memRsp_t m, input logic fl);
		laneBusPkg::wbReq_t r;
		int sh;
		logic [63:0] up;
		logic signed [63:0] sUp;
		r = '{gprId: op.regIdRn1, gprVal: op.regValRn1, crId: op.regIdCn1,
			crVal: op.regValCn1, hold: isMemOp(op.cmd) && m.ok[1]}; // Busy or fault
		sh = 64 - (8 << op.ixt.ld.size); // Bits above the loaded size
		up = m.data << sh; // Loaded value parked at the top
		sUp = up;
		if (op.cmd == uopPkg::UCMD_MOV_MR) begin
			r.gprId = op.regIdRm;
			if (op.ixt.ld.isUnsigned) r.gprVal = up >> sh;
			else r.gprVal = sUp >>> sh; // Sign comes back down with it
		end else if (op.cmd == uopPkg::UCMD_MUL3 || op.cmd == uopPkg::UCMD_FPUV4SF) begin
			r.gprId = op.regIdRm;
			r.gprVal = (op.cmd == uopPkg::UCMD_MUL3) ? op.mulRes : op.fpuRes;
		end else if (op.cmd == uopPkg::UCMD_OP_IXT && op.ixt.sub == uopPkg::IXT_MOVDLR) begin
			r.gprId = 5'd1;
			r.gprVal = op.keyRes[63:0];
		end else if (op.cmd == uopPkg::UCMD_OP_IXT && op.ixt.sub == uopPkg::IXT_LDCR
				&& op.keyRes[65:64] == 2'b10) begin
			r.crId = 3'd1; // Key tag good
			r.crVal = op.keyRes[63:0];
		end
		if (fl) begin
			r.gprId = gprZzr; // Killed op keeps its hold
			r.crId = crZzr;
		end
		return r;
	endfunction

	task automatic checkValue(input string name, input logic [63:0] expVal,
			input logic [63:0] actVal);
		if (actVal !== expVal) begin
			errorCount++;
			$display("[ERROR] %s expected %h actual %h at %0t", name, expVal, actVal, $time);
		end
	endtask

	// Pre-edge values with inputs settled since the falling edge
	always @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `CORE_LANES; i++) begin
				mEx3[i] = '0; // NOP with zero ids
				mRet[i] = '0;
			end
			for (int r = 0; r < `CORE_GPRS; r++) mGpr[r] = '0;
			mFault = '0;
		end else begin
			expStall = 1'b0;
			for (int i = 0; i < `CORE_LANES; i++) begin
				req[i] = expectReq(mEx3[i], memRsp[i], flush);
				expStall = expStall | req[i].hold;
			end
			checkValue("stall", 64'(expStall), 64'(stall));
			checkValue("dbgGprVal", mGpr[dbgGprId], dbgGprVal);
			for (int i = 0; i < `CORE_LANES; i++) begin
				checkValue($sformatf("retire[%0d].gprWe", i), 64'(mRet[i].gprWe),
					64'(retire[i].gprWe));
				checkValue($sformatf("retire[%0d].crWe", i), 64'(mRet[i].crWe),
					64'(retire[i].crWe));
				checkValue($sformatf("laneFault[%0d]", i), 64'(mFault[i]), 64'(laneFault[i]));
				if (mRet[i].gprWe && retire[i].gprWe) begin
					checkValue($sformatf("retire[%0d].gprId", i), 64'(mRet[i].gprId),
						64'(retire[i].gprId));
					checkValue($sformatf("retire[%0d].gprVal", i), mRet[i].gprVal,
						retire[i].gprVal);
				end
				if (mRet[i].crWe && retire[i].crWe) begin
					checkValue($sformatf("retire[%0d].crId", i), 64'(mRet[i].crId),
						64'(retire[i].crId));
					checkValue($sformatf("retire[%0d].crVal", i), mRet[i].crVal, retire[i].crVal);
				end
			end
			// Step the model in lane order so the higher lane lands last
			for (int i = 0; i < `CORE_LANES; i++) begin
				mRet[i] = '{gprWe: !expStall && req[i].gprId != gprZzr, gprId: req[i].gprId,
					gprVal: req[i].gprVal, crWe: !expStall && req[i].crId != crZzr,
					crId: req[i].crId, crVal: req[i].crVal};
				if (mRet[i].gprWe) mGpr[req[i].gprId] = req[i].gprVal;
				if (isMemOp(mEx3[i].cmd) && memRsp[i].ok == 2'b11) mFault[i] = 1'b1;
			end
			if (!expStall) begin
				for (int i = 0; i < `CORE_LANES; i++) mEx3[i] = laneIn[i]; // Latch loads
			end
		end
	end

endmodule

//--- verif/exPipeTb.sv
// ##############################
// Testbench top
// DUT, random bundles from a fixed seed,
// cycle budget and closing report
// ##############################

`timescale 1ns/1ps

`include "core_defines.svh"

module exPipeTb;

	localparam int mixCycles = 400; // Full id range
	localparam int collideCycles = 300; // Ids squeezed so lanes collide
	localparam int faultCycles = 120; // Late window with faults
	localparam int cycleLimit = mixCycles + collideCycles + faultCycles + 100;

	logic clock;
	logic reset;
	laneBusPkg::ex2Bus_t [`CORE_LANES-1:0] laneIn;
	laneBusPkg::memRsp_t [`CORE_LANES-1:0] memRsp;
	logic flush;
	uopPkg::gprId_t dbgGprId;
	logic stall;
	laneBusPkg::retire_t [`CORE_LANES-1:0] retire;
	logic [`CORE_LANES-1:0] laneFault;
	logic [63:0] dbgGprVal;
	int errorCount;
	int cycles = 0;
	integer seed = 87931;

	tbClockGen clkGen_i (.*);
	exPipeTop dut_i (.*);
	exPipeChecker checker_i (.*);

	// One random bundle, set up on the falling edge
	task automatic driveBundle(input uopPkg::gprId_t idMask, input bit faultWindow);
		int pick;
		@(negedge clock);
		for (int i = 0; i < `CORE_LANES; i++) begin
			laneIn[i].cmd = uopPkg::uCmd_t'(6'($random(seed) & 7)); // 7 unhandled
			laneIn[i].ixt = uopPkg::uIxt_u'(6'($random(seed)));
			if (laneIn[i].cmd == uopPkg::UCMD_OP_IXT && $random(seed) % 4 != 0)
				laneIn[i].ixt.sub = ($random(seed) & 1) ? uopPkg::IXT_LDCR : uopPkg::IXT_MOVDLR;
			laneIn[i].regIdRm = uopPkg::gprId_t'($random(seed)) & idMask;
			laneIn[i].regIdRn1 = uopPkg::gprId_t'($random(seed)) & idMask;
			laneIn[i].regIdCn1 = uopPkg::crId_t'($random(seed)) & idMask[2:0];
			laneIn[i].regValRn1 = {$random(seed), $random(seed)};
			laneIn[i].regValCn1 = {$random(seed), $random(seed)};
			laneIn[i].mulRes = {$random(seed), $random(seed)};
			laneIn[i].fpuRes = {$random(seed), $random(seed)};
			laneIn[i].keyRes = {2'($random(seed)), $random(seed), $random(seed)}; // Random tag
			memRsp[i].data = {$random(seed), $random(seed)};
			pick = {$random(seed)} % 16;
			if (pick == 0) memRsp[i].ok = 2'b10; // Busy now and then
			else if (faultWindow && pick == 1) memRsp[i].ok = 2'b11;
			else memRsp[i].ok = 2'b00;
		end
		flush = ({$random(seed)} % 10) == 0; // About one in ten
		dbgGprId = uopPkg::gprId_t'($random(seed));
	endtask

	initial begin
		laneIn = '0;
		memRsp = '0;
		flush = 1'b0;
		dbgGprId = '0;
		@(negedge reset);
		repeat (mixCycles) driveBundle(5'h1f, 1'b0);
		repeat (collideCycles) driveBundle(5'h03, 1'b0);
		repeat (faultCycles) driveBundle(5'h1f, 1'b1);
		@(negedge clock);
		laneIn = '0; // Empty slots, memory ready
		memRsp = '0;
		flush = 1'b0;
		repeat (4) @(negedge clock); // Last ops retire and get checked
		$display("Closing report: %0d errors in %0d cycles", errorCount, cycles);
		if (errorCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Budget is the sum of the phases plus drain margin
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Timeout after %0d cycles, stimulus did not finish", cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

endmodule

//--- verif/tbClockGen.sv
// ##############################
// Testbench clock and reset
// 8 ns clock, reset held two edges
// ##############################

`timescale 1ns/1ps

module tbClockGen (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock; // 8 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0; // Released away from the active edge
	end

endmodule

//--- verilog/core_defines.svh
// ##############################
// Core sizing macros
// Lane count, register file depths
// and the discard register id
// ##############################

`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Parallel execute lanes
`define CORE_LANES 3

`define CORE_GPRS 32 // General registers
`define CORE_CRS 8 // Control registers

// Discard register, same id in both files
`define CORE_ZZR 0

`endif

//--- verilog/exPipeTop.sv
// ##############################
// EX3 pipeline top
// Latch, generated lanes, writeback
// ##############################

`timescale 1ns/1ps

`include "core_defines.svh"

module exPipeTop (
	input logic clock,
	input logic reset,
	input laneBusPkg::ex2Bus_t [`CORE_LANES-1:0] laneIn,
	input laneBusPkg::memRsp_t [`CORE_LANES-1:0] memRsp,
	input logic flush,
	output logic stall,
	output laneBusPkg::retire_t [`CORE_LANES-1:0] retire,
	output logic [`CORE_LANES-1:0] laneFault,
	input uopPkg::gprId_t dbgGprId,
	output logic [63:0] dbgGprVal
);

	laneBusPkg::ex2Bus_t [`CORE_LANES-1:0] ex3Op; // Ops sitting in EX3
	laneBusPkg::wbReq_t [`CORE_LANES-1:0] wbReq;

	exStage2Latch latch_i (
		.clock(clock),
		.reset(reset),
		.laneIn(laneIn),
		.stall(stall), // Freeze while any lane waits
		.ex3Op(ex3Op)
	);

	for (genvar i = 0; i < `CORE_LANES; i++) begin : genLane
		exStage3Lane lane_i (
			.clock(clock),
			.reset(reset),
			.op(ex3Op[i]),
			.mem(memRsp[i]),
			.flush(flush), // Branch flush hits all lanes
			.req(wbReq[i]),
			.fault(laneFault[i])
		);
	end

	exWriteback wb_i (
		.clock(clock),
		.reset(reset),
		.req(wbReq),
		.stall(stall),
		.retire(retire),
		.dbgGprId(dbgGprId),
		.dbgGprVal(dbgGprVal)
	);

endmodule

//--- verilog/exStage2Latch.sv
// ##############################
// EX2 to EX3 pipeline register
// All lanes load together, freeze on stall
// ##############################

`timescale 1ns/1ps

`include "core_defines.svh"

module exStage2Latch (
	input logic clock,
	input logic reset,
	input laneBusPkg::ex2Bus_t [`CORE_LANES-1:0] laneIn,
	input logic stall,
	output laneBusPkg::ex2Bus_t [`CORE_LANES-1:0] ex3Op
);

	localparam uopPkg::gprId_t gprZzr = uopPkg::gprId_t'(`CORE_ZZR);
	localparam uopPkg::crId_t crZzr = uopPkg::crId_t'(`CORE_ZZR);

	// Reset leaves an empty NOP slot with discard ids in every lane
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `CORE_LANES; i++) begin
				ex3Op[i].cmd <= uopPkg::UCMD_NOP; // Empty slot
				ex3Op[i].regIdRn1 <= gprZzr; // Retires nothing
				ex3Op[i].regIdCn1 <= crZzr;
			end
		end else if (!stall) begin
			ex3Op <= laneIn; // Whole bundle advances at once
		end
		// Under stall the same ops stay in EX3
	end

endmodule

//--- verilog/exStage3Lane.sv
// ##############################
// One EX3 lane
// Destination select, load extension,
// memory hold and sticky fault flag
// ##############################

`timescale 1ns/1ps

`include "core_defines.svh"

module exStage3Lane (
	input logic clock,
	input logic reset,
	input laneBusPkg::ex2Bus_t op,
	input laneBusPkg::memRsp_t mem,
	input logic flush,
	output laneBusPkg::wbReq_t req,
	output logic fault
);

	localparam uopPkg::gprId_t gprZzr = uopPkg::gprId_t'(`CORE_ZZR);
	localparam uopPkg::crId_t crZzr = uopPkg::crId_t'(`CORE_ZZR);
	localparam uopPkg::gprId_t gprDlr = uopPkg::gprId_t'(1); // MOVDLR target
	localparam uopPkg::crId_t crKrr = uopPkg::crId_t'(1); // LDCR target
	localparam logic [1:0] keyTagOk = 2'b10;

	logic memOp; // Load or store in EX3
	logic memFault;
	logic outDfl; // Result goes to Rm
	logic [63:0] valOut;
	logic [63:0] loadVal;
	logic signFill;

	// Load size and sign come from the union's load view
	assign signFill = !op.ixt.ld.isUnsigned;

	always_comb begin
		case (op.ixt.ld.size)
			uopPkg::LD_BYTE: begin
				loadVal = {{56{signFill & mem.data[7]}}, mem.data[7:0]};
			end
			uopPkg::LD_HALF: begin
				loadVal = {{48{signFill & mem.data[15]}}, mem.data[15:0]};
			end
			uopPkg::LD_WORD: begin
				loadVal = {{32{signFill & mem.data[31]}}, mem.data[31:0]};
			end
			default: begin
				loadVal = mem.data; // Quad, nothing to extend
			end
		endcase
	end

	always_comb begin
		// Forward the EX1/EX2 pair unless the op says otherwise
		req.gprId = op.regIdRn1;
		req.gprVal = op.regValRn1;
		req.crId = op.regIdCn1;
		req.crVal = op.regValCn1;
		req.hold = 1'b0;
		memOp = 1'b0;
		outDfl = 1'b0;
		valOut = '0;

		case (op.cmd)
			uopPkg::UCMD_MOV_RM: begin
				memOp = 1'b1; // Store, only waits on memory
			end
			uopPkg::UCMD_MOV_MR: begin
				memOp = 1'b1;
				valOut = loadVal;
				outDfl = 1'b1;
			end
			uopPkg::UCMD_MUL3: begin
				valOut = op.mulRes;
				outDfl = 1'b1;
			end
			uopPkg::UCMD_FPUV4SF: begin
				valOut = op.fpuRes;
				outDfl = 1'b1;
			end
			uopPkg::UCMD_OP_IXT: begin
				// Extension field read as a sub-op here
				case (op.ixt.sub)
					uopPkg::IXT_LDCR: begin
						if (op.keyRes[65:64] == keyTagOk) begin
							req.crId = crKrr;
							req.crVal = op.keyRes[63:0];
						end
					end
					uopPkg::IXT_MOVDLR: begin
						req.gprId = gprDlr;
						req.gprVal = op.keyRes[63:0];
					end
					default: begin
					end
				endcase
			end
			default: begin
				// NOP, ALU3 and unknown opcodes just forward
			end
		endcase

		if (outDfl) begin
			req.gprId = op.regIdRm;
			req.gprVal = valOut;
		end

		if (memOp && mem.ok[1]) begin
			req.hold = 1'b1; // Busy or fault
		end

		// Killed op keeps its hold but writes nothing
		if (flush) begin
			req.gprId = gprZzr;
			req.crId = crZzr;
		end
	end

	assign memFault = memOp && (mem.ok == 2'b11);

	always_ff @(posedge clock) begin
		if (reset) begin
			fault <= 1'b0;
		end else if (memFault) begin
			fault <= 1'b1; // Sticky until reset
		end
	end

	// Stall only ever originates from a memory op
	holdOnlyOnMemOp: assert property (@(posedge clock) disable iff (reset)
		req.hold |-> (op.cmd == uopPkg::UCMD_MOV_MR || op.cmd == uopPkg::UCMD_MOV_RM));

	faultSticky: assert property (@(posedge clock) disable iff (reset)
		fault |=> fault);

endmodule

//--- verilog/exWriteback.sv
// ##############################
// Writeback
// Stall merge, retire registers,
// GPR file and its debug read
// ##############################

`timescale 1ns/1ps

`include "core_defines.svh"

module exWriteback (
	input logic clock,
	input logic reset,
	input laneBusPkg::wbReq_t [`CORE_LANES-1:0] req,
	output logic stall,
	output laneBusPkg::retire_t [`CORE_LANES-1:0] retire,
	input uopPkg::gprId_t dbgGprId,
	output logic [63:0] dbgGprVal
);

	localparam uopPkg::gprId_t gprZzr = uopPkg::gprId_t'(`CORE_ZZR);
	localparam uopPkg::crId_t crZzr = uopPkg::crId_t'(`CORE_ZZR);

	logic [63:0] gprFile [`CORE_GPRS];
	logic anyRetireWe;

	// Any lane waiting on memory holds the whole bundle
	always_comb begin
		stall = 1'b0;
		for (int i = 0; i < `CORE_LANES; i++) begin
			stall = stall | req[i].hold;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `CORE_LANES; i++) begin
				retire[i].gprWe <= 1'b0;
				retire[i].crWe <= 1'b0;
			end
		end else begin
			for (int i = 0; i < `CORE_LANES; i++) begin
				retire[i].gprWe <= !stall && (req[i].gprId != gprZzr);
				retire[i].gprId <= req[i].gprId;
				retire[i].gprVal <= req[i].gprVal;
				retire[i].crWe <= !stall && (req[i].crId != crZzr);
				retire[i].crId <= req[i].crId;
				retire[i].crVal <= req[i].crVal;
			end
		end
	end

	// Lanes applied low to high, so the higher lane wins a collision
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int r = 0; r < `CORE_GPRS; r++) begin
				gprFile[r] <= '0;
			end
		end else if (!stall) begin
			for (int i = 0; i < `CORE_LANES; i++) begin
				if (req[i].gprId != gprZzr) begin
					gprFile[req[i].gprId] <= req[i].gprVal;
				end
			end
		end
	end

	assign dbgGprVal = gprFile[dbgGprId]; // Id 0 always reads zero

	always_comb begin
		anyRetireWe = 1'b0;
		for (int i = 0; i < `CORE_LANES; i++) begin
			anyRetireWe = anyRetireWe | retire[i].gprWe | retire[i].crWe;
		end
	end

	// A held bundle must not retire on the following edge
	noRetireAfterStall: assert property (@(posedge clock) disable iff (reset)
		stall |=> !anyRetireWe);

endmodule

//--- verilog/laneBusPkg.sv
// ##############################
// Stage buses
// EX2 op, memory response, writeback
// request and retire record per lane
// ##############################

package laneBusPkg;

	// One lane leaving EX2
	typedef struct packed {
		uopPkg::uCmd_t cmd;
		uopPkg::uIxt_u ixt;
		uopPkg::gprId_t regIdRm; // Dest for load, MUL, FPU
		uopPkg::gprId_t regIdRn1; // Forwarded GPR dest
		logic [63:0] regValRn1;
		uopPkg::crId_t regIdCn1; // Forwarded CR dest
		logic [63:0] regValCn1;
		logic [63:0] mulRes;
		logic [63:0] fpuRes;
		logic [65:0] keyRes; // Tag in [65:64]
	} ex2Bus_t;

	// ok: 00 ready, 10 busy, 11 fault
	typedef struct packed {
		logic [63:0] data;
		logic [1:0] ok;
	} memRsp_t;

	typedef struct packed {
		uopPkg::gprId_t gprId;
		logic [63:0] gprVal;
		uopPkg::crId_t crId;
		logic [63:0] crVal;
		logic hold; // Lane waits on memory
	} wbReq_t;

	typedef struct packed {
		logic gprWe;
		uopPkg::gprId_t gprId;
		logic [63:0] gprVal;
		logic crWe;
		uopPkg::crId_t crId;
		logic [63:0] crVal;
	} retire_t;

endpackage

//--- verilog/uopPkg.sv
// ##############################
// Micro-op encodings
// Opcodes, IXT sub-ops, load control,
// the shared extension field union and register ids
// ##############################

`include "core_defines.svh"

package uopPkg;

	// Major opcode, anything else is treated as NOP
	typedef enum logic [5:0] {
		UCMD_NOP = 6'h00,
		UCMD_ALU3 = 6'h01,
		UCMD_MOV_MR = 6'h02, // Load
		UCMD_MOV_RM = 6'h03, // Store
		UCMD_MUL3 = 6'h04,
		UCMD_OP_IXT = 6'h05,
		UCMD_FPUV4SF = 6'h06
	} uCmd_t;

	// Keyring sub-ops under OP_IXT
	typedef enum logic [5:0] {
		IXT_LDCR = 6'h10, // Key result to CR1, tag checked
		IXT_MOVDLR = 6'h11 // Key result to GR1
	} ixtOp_t;

	typedef enum logic [1:0] {
		LD_BYTE = 2'd0,
		LD_HALF = 2'd1,
		LD_WORD = 2'd2,
		LD_QUAD = 2'd3
	} loadSize_t;

	typedef struct packed {
		logic [2:0] pad; // Spare
		logic isUnsigned; // Zero extend when set
		loadSize_t size;
	} loadCtl_t;

	// Same six bits, sub-op for OP_IXT and load control for MOV_MR
	typedef union packed {
		ixtOp_t sub;
		loadCtl_t ld;
	} uIxt_u;

	typedef logic [$clog2(`CORE_GPRS)-1:0] gprId_t;
	typedef logic [$clog2(`CORE_CRS)-1:0] crId_t;

endpackage
